// File: design/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] pc_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [3:0] opcode_t;
	typedef logic [1:0] fwd_sel_t;

	// Instruction format: opcode, rd, rs1, rs2, imm16.
	localparam opcode_t OP_NOP  = 4'd0;
	localparam opcode_t OP_ADD  = 4'd1;
	localparam opcode_t OP_SUB  = 4'd2;
	localparam opcode_t OP_AND  = 4'd3;
	localparam opcode_t OP_OR   = 4'd4;
	localparam opcode_t OP_XOR  = 4'd5;
	localparam opcode_t OP_ADDI = 4'd6;
	localparam opcode_t OP_LD   = 4'd7;
	localparam opcode_t OP_ST   = 4'd8;
	localparam opcode_t OP_BEQZ = 4'd9;
	localparam opcode_t OP_HALT = 4'd15;

	// Operand sources for the execute stage.
	localparam fwd_sel_t FWD_REG = 2'd0;
	localparam fwd_sel_t FWD_EX  = 2'd1;
	localparam fwd_sel_t FWD_MEM = 2'd2;

	localparam word_t NOP_IR = 32'h0000_0000;

	localparam int RAM_AWIDTH = 10;
	localparam pc_t DATA_BASE = 32'h0000_0800;

endpackage

// File: design/cyc_bus_if.sv
`timescale 1ns/1ps

interface cyc_bus_if;
	import cpu_pkg::*;

	logic       cyc;
	logic       we;
	logic [3:0] sel;
	pc_t        adr;
	word_t      wdat;
	word_t      rdat;
	logic       ack;

	modport master (output cyc, we, sel, adr, wdat, input rdat, ack);
	modport slave  (input cyc, we, sel, adr, wdat, output rdat, ack);

endinterface

// File: design/stage_if.sv
`timescale 1ns/1ps

interface stage_if;
	import cpu_pkg::*;

	word_t     ir;
	pc_t       pc;
	logic      wr_en;
	reg_addr_t rd;
	word_t     data1;
	word_t     data2;

	modport source (output ir, pc, wr_en, rd, data1, data2);
	modport sink   (input ir, pc, wr_en, rd, data1, data2);

endinterface

// File: design/ifetch.sv
`timescale 1ns/1ps

module ifetch (
	input  logic            clk_i,
	input  logic            reset_i,
	cyc_bus_if.master       bus,
	input  logic            stall_i,
	input  logic            pc_set_i,
	input  cpu_pkg::pc_t    pc_target_i,
	input  logic            halt_i,
	output cpu_pkg::word_t  ir_o,
	output cpu_pkg::pc_t    pc_o
);
	import cpu_pkg::*;

	typedef enum logic {FETCH_IDLE, FETCH_WAIT} fetch_state_t;

	fetch_state_t state;
	pc_t   pc;
	pc_t   fadr;
	word_t word;
	logic  word_valid;
	logic  drop;
	logic  halted;
	logic  go;

	// A new fetch starts only once the held word will be taken.
	assign go = !halt_i && !halted && !pc_set_i && (!word_valid || !stall_i);

	assign bus.cyc  = (state == FETCH_WAIT);
	assign bus.we   = 1'b0;
	assign bus.sel  = 4'hf;
	assign bus.adr  = fadr;
	assign bus.wdat = '0;

	assign ir_o = word_valid ? word : NOP_IR;

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			state      <= FETCH_IDLE;
			pc         <= '0;
			word_valid <= 1'b0;
			drop       <= 1'b0;
			halted     <= 1'b0;
		end
		else
		begin
			case (state)
				FETCH_IDLE:
					if (go)
					begin
						state <= FETCH_WAIT;
						drop  <= 1'b0;
					end
				FETCH_WAIT:
					if (bus.ack)
						state <= FETCH_IDLE;
				default: state <= FETCH_IDLE;
			endcase
			if (pc_set_i)
			begin
				pc         <= pc_target_i;
				word_valid <= 1'b0;
				halted     <= 1'b0;
				if (state == FETCH_WAIT && !bus.ack)
					drop <= 1'b1;
			end
			else
			begin
				if (!stall_i)
					word_valid <= 1'b0;
				if (state == FETCH_WAIT && bus.ack && !drop)
				begin
					word_valid <= 1'b1;
					pc         <= fadr + 32'd4;
					// Stop fetching past a HALT.
					if (bus.rdat[31:28] == OP_HALT)
						halted <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (state == FETCH_IDLE && go)
			fadr <= pc;
		if (state == FETCH_WAIT && bus.ack)
		begin
			word <= bus.rdat;
			pc_o <= fadr;
		end
	end

	a_cyc_until_ack: assert property (@(posedge clk_i) disable iff (reset_i)
		bus.cyc && !bus.ack |=> bus.cyc && bus.ack);

endmodule

// File: design/idecode.sv
`timescale 1ns/1ps

module idecode (
	input  logic               clk_i,
	input  logic               reset_i,
	input  cpu_pkg::word_t     ir_i,
	input  cpu_pkg::pc_t       pc_i,
	input  logic               stall_i,
	input  logic               wb_en_i,
	input  cpu_pkg::reg_addr_t wb_addr_i,
	input  cpu_pkg::word_t     wb_data_i,
	stage_if.source            out
);
	import cpu_pkg::*;

	word_t     rf [16];
	opcode_t   op;
	reg_addr_t rs1;
	reg_addr_t rs2;
	logic      writes;

	assign op  = ir_i[31:28];
	assign rs1 = ir_i[23:20];
	assign rs2 = ir_i[19:16];

	always_comb
	begin
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LD: writes = 1'b1;
			default: writes = 1'b0;
		endcase
	end

	// Read port with r0 forced to zero and write-through from writeback.
	function automatic word_t read_port(reg_addr_t a);
		if (a == '0)
			return '0;
		if (wb_en_i && wb_addr_i == a)
			return wb_data_i;
		return rf[a];
	endfunction

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			out.ir    <= NOP_IR;
			out.wr_en <= 1'b0;
		end
		else if (!stall_i)
		begin
			out.ir    <= ir_i;
			out.wr_en <= writes;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (wb_en_i && wb_addr_i != '0)
			rf[wb_addr_i] <= wb_data_i;
		if (!stall_i)
		begin
			out.pc    <= pc_i;
			out.rd    <= ir_i[27:24];
			out.data1 <= read_port(rs1);
			out.data2 <= read_port(rs2);
		end
	end

endmodule

// File: design/hazard.sv
`timescale 1ns/1ps

module hazard (
	input  cpu_pkg::word_t    if_ir_i,
	input  cpu_pkg::word_t    id_ir_i,
	input  cpu_pkg::word_t    ex_ir_i,
	input  logic              id_wr_i,
	input  logic              ex_wr_i,
	output cpu_pkg::fwd_sel_t sel1_o,
	output cpu_pkg::fwd_sel_t sel2_o,
	output logic              stall_o
);
	import cpu_pkg::*;

	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t id_rd;
	reg_addr_t ex_rd;
	logic      id_ld;

	assign rs1   = if_ir_i[23:20];
	assign rs2   = if_ir_i[19:16];
	assign id_rd = id_ir_i[27:24];
	assign ex_rd = ex_ir_i[27:24];
	assign id_ld = id_wr_i && (id_ir_i[31:28] == OP_LD);

	// Youngest older writer wins.
	function automatic fwd_sel_t pick(reg_addr_t rs);
		if (rs == '0)
			return FWD_REG;
		if (id_wr_i && id_rd == rs)
			return FWD_EX;
		if (ex_wr_i && ex_rd == rs)
			return FWD_MEM;
		return FWD_REG;
	endfunction

	assign stall_o = id_ld && ((rs1 != '0 && rs1 == id_rd) || (rs2 != '0 && rs2 == id_rd));

	// A stalled word enters decode as a bubble, so its selects are moot.
	always_comb
	begin
		sel1_o = stall_o ? FWD_REG : pick(rs1);
		sel2_o = stall_o ? FWD_REG : pick(rs2);
	end

endmodule

// File: design/execute.sv
`timescale 1ns/1ps

module execute (
	input  logic           clk_i,
	input  logic           reset_i,
	stage_if.sink          in,
	input  cpu_pkg::word_t data1_i,
	input  cpu_pkg::word_t data2_i,
	input  logic           stall_i,
	stage_if.source        out,
	output logic           pc_set_o,
	output cpu_pkg::pc_t   pc_target_o,
	output cpu_pkg::word_t result_o
);
	import cpu_pkg::*;

	opcode_t op;
	word_t   imm;
	word_t   alu;

	assign op  = in.ir[31:28];
	assign imm = {{16{in.ir[15]}}, in.ir[15:0]};

	always_comb
	begin
		case (op)
			OP_ADD:               alu = data1_i + data2_i;
			OP_SUB:               alu = data1_i - data2_i;
			OP_AND:               alu = data1_i & data2_i;
			OP_OR:                alu = data1_i | data2_i;
			OP_XOR:               alu = data1_i ^ data2_i;
			OP_ADDI, OP_LD, OP_ST: alu = data1_i + imm;
			default:              alu = '0;
		endcase
	end

	// Branch offset counts words from the next instruction.
	assign pc_set_o    = (op == OP_BEQZ) && (data1_i == '0) && !stall_i;
	assign pc_target_o = in.pc + 32'd4 + {imm[29:0], 2'b00};

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			out.ir    <= NOP_IR;
			out.wr_en <= 1'b0;
		end
		else if (!stall_i)
		begin
			out.ir    <= in.ir;
			out.wr_en <= in.wr_en;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (!stall_i)
		begin
			out.pc    <= in.pc;
			out.rd    <= in.rd;
			out.data1 <= alu;
			out.data2 <= data2_i;
		end
	end

	assign result_o = out.data1;

	// The flush of decode keeps a second branch from following.
	a_pc_set_single: assert property (@(posedge clk_i) disable iff (reset_i)
		pc_set_o |=> !pc_set_o);

endmodule

// File: design/mem.sv
`timescale 1ns/1ps

module mem (
	input  logic               clk_i,
	input  logic               reset_i,
	stage_if.sink              in,
	cyc_bus_if.master          bus,
	output logic               stall_o,
	output logic               wb_en_o,
	output cpu_pkg::reg_addr_t wb_addr_o,
	output cpu_pkg::word_t     wb_data_o,
	output logic               halt_o
);
	import cpu_pkg::*;

	typedef enum logic {MEM_IDLE, MEM_WAIT} mem_state_t;

	mem_state_t state;
	opcode_t    op;
	logic       mem_op;
	logic       done;

	assign op     = in.ir[31:28];
	assign mem_op = (op == OP_LD) || (op == OP_ST);
	assign done   = (state == MEM_WAIT) && bus.ack;
	assign stall_o = mem_op && !done;

	assign bus.cyc  = (state == MEM_WAIT);
	assign bus.we   = (op == OP_ST);
	assign bus.sel  = 4'hf;
	assign bus.adr  = in.data1;
	assign bus.wdat = in.data2;

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			state   <= MEM_IDLE;
			wb_en_o <= 1'b0;
			halt_o  <= 1'b0;
		end
		else
		begin
			case (state)
				MEM_IDLE:
					if (mem_op)
						state <= MEM_WAIT;
				MEM_WAIT:
					if (bus.ack)
						state <= MEM_IDLE;
				default: state <= MEM_IDLE;
			endcase
			wb_en_o <= !stall_o && in.wr_en;
			if (op == OP_HALT)
				halt_o <= 1'b1;
		end
	end

	// Holds the last writer so that decode can still forward from it.
	always_ff @(posedge clk_i)
	begin
		if (!stall_o && in.wr_en)
		begin
			wb_addr_o <= in.rd;
			wb_data_o <= (op == OP_LD) ? bus.rdat : in.data1;
		end
	end

	a_data_region: assert property (@(posedge clk_i) disable iff (reset_i)
		bus.cyc |-> bus.adr >= DATA_BASE);

endmodule

// File: design/ram2.sv
`timescale 1ns/1ps

module ram2 #(
	parameter int AWIDTH = cpu_pkg::RAM_AWIDTH
) (
	input  logic              clk_i,
	input  logic              reset_i,
	cyc_bus_if.slave          p0,
	cyc_bus_if.slave          p1,
	input  logic              load_we_i,
	input  logic [AWIDTH-1:0] load_adr_i,
	input  cpu_pkg::word_t    load_dat_i
);
	import cpu_pkg::*;

	word_t             ram_q [2**AWIDTH];
	logic [AWIDTH-1:0] a0;
	logic [AWIDTH-1:0] a1;

	assign a0 = p0.adr[AWIDTH+1:2];
	assign a1 = p1.adr[AWIDTH+1:2];

	always_ff @(posedge clk_i)
	begin
		if (load_we_i)
			ram_q[load_adr_i] <= load_dat_i;
		else if (p0.cyc && p0.we && !p0.ack)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (p0.sel[b])
					ram_q[a0][8*b +: 8] <= p0.wdat[8*b +: 8];
			end
		end
		p0.rdat <= ram_q[a0];
		p1.rdat <= ram_q[a1];
	end

	// One ack per request, the cycle after cyc is seen.
	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			p0.ack <= 1'b0;
			p1.ack <= 1'b0;
		end
		else
		begin
			p0.ack <= p0.cyc && !p0.ack;
			p1.ack <= p1.cyc && !p1.ack;
		end
	end

endmodule

// File: design/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  logic                          load_we_i,
	input  logic [cpu_pkg::RAM_AWIDTH-1:0] load_adr_i,
	input  cpu_pkg::word_t                load_dat_i,
	output logic                          wb_valid_o,
	output cpu_pkg::reg_addr_t            wb_addr_o,
	output cpu_pkg::word_t                wb_data_o,
	output logic                          dat_cyc_o,
	output logic                          dat_we_o,
	output cpu_pkg::pc_t                  dat_adr_o,
	output cpu_pkg::word_t                dat_dat_o,
	output logic                          halt_o
);
	import cpu_pkg::*;

	cyc_bus_if ins_bus ();
	cyc_bus_if dat_bus ();
	stage_if   id_stage ();
	stage_if   ex_stage ();

	word_t    if_ir;
	pc_t      if_pc;
	word_t    fetch_ir;
	word_t    decode_ir;
	logic     hazard_stall;
	logic     mem_stall;
	logic     pc_set;
	pc_t      pc_target;
	fwd_sel_t sel1;
	fwd_sel_t sel2;
	fwd_sel_t sel1_q;
	fwd_sel_t sel2_q;
	word_t    ex_result;
	word_t    exe_data1;
	word_t    exe_data2;

	// A taken branch squashes the fetched word; a load-use stall sends a bubble.
	assign fetch_ir  = pc_set ? NOP_IR : if_ir;
	assign decode_ir = hazard_stall ? NOP_IR : fetch_ir;

	ifetch fetch0 (.clk_i(clk_i), .reset_i(reset_i), .bus(ins_bus.master),
		.stall_i(hazard_stall | mem_stall), .pc_set_i(pc_set),
		.pc_target_i(pc_target), .halt_i(halt_o), .ir_o(if_ir), .pc_o(if_pc));

	idecode decode0 (.clk_i(clk_i), .reset_i(reset_i), .ir_i(decode_ir), .pc_i(if_pc),
		.stall_i(mem_stall), .wb_en_i(wb_valid_o), .wb_addr_i(wb_addr_o),
		.wb_data_i(wb_data_o), .out(id_stage.source));

	hazard hazard0 (.if_ir_i(fetch_ir), .id_ir_i(id_stage.ir), .ex_ir_i(ex_stage.ir),
		.id_wr_i(id_stage.wr_en), .ex_wr_i(ex_stage.wr_en),
		.sel1_o(sel1), .sel2_o(sel2), .stall_o(hazard_stall));

	// Selects follow the word into decode.
	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			sel1_q <= FWD_REG;
			sel2_q <= FWD_REG;
		end
		else if (!mem_stall)
		begin
			sel1_q <= sel1;
			sel2_q <= sel2;
		end
	end

	function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf_val, word_t ex_val,
		word_t mem_val);
		case (sel)
			FWD_EX:  return ex_val;
			FWD_MEM: return mem_val;
			default: return rf_val;
		endcase
	endfunction

	assign exe_data1 = fwd_mux(sel1_q, id_stage.data1, ex_result, wb_data_o);
	assign exe_data2 = fwd_mux(sel2_q, id_stage.data2, ex_result, wb_data_o);

	execute exe0 (.clk_i(clk_i), .reset_i(reset_i), .in(id_stage.sink),
		.data1_i(exe_data1), .data2_i(exe_data2), .stall_i(mem_stall),
		.out(ex_stage.source), .pc_set_o(pc_set), .pc_target_o(pc_target),
		.result_o(ex_result));

	mem mem0 (.clk_i(clk_i), .reset_i(reset_i), .in(ex_stage.sink), .bus(dat_bus.master),
		.stall_o(mem_stall), .wb_en_o(wb_valid_o), .wb_addr_o(wb_addr_o),
		.wb_data_o(wb_data_o), .halt_o(halt_o));

	ram2 #(.AWIDTH(RAM_AWIDTH)) ram0 (.clk_i(clk_i), .reset_i(reset_i),
		.p0(dat_bus.slave), .p1(ins_bus.slave), .load_we_i(load_we_i),
		.load_adr_i(load_adr_i), .load_dat_i(load_dat_i));

	assign dat_cyc_o = dat_bus.cyc;
	assign dat_we_o  = dat_bus.we;
	assign dat_adr_o = dat_bus.adr;
	assign dat_dat_o = dat_bus.wdat;

endmodule

// File: test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT      = 2000;
	localparam int QUIET_CYCLES = 50;

	logic                  clk_i;
	logic                  reset_i;
	logic                  load_we_i;
	logic [RAM_AWIDTH-1:0] load_adr_i;
	word_t                 load_dat_i;
	logic                  wb_valid_o;
	reg_addr_t             wb_addr_o;
	word_t                 wb_data_o;
	logic                  dat_cyc_o;
	logic                  dat_we_o;
	pc_t                   dat_adr_o;
	word_t                 dat_dat_o;
	logic                  halt_o;

	logic [RAM_AWIDTH-1:0] prog_adr [$];
	word_t                 prog_dat [$];
	reg_addr_t             wb_rd_exp [$];
	word_t                 wb_val_exp [$];
	pc_t                   st_adr_exp [$];
	word_t                 st_val_exp [$];
	logic                  cyc_q;

	cpu_top cpu_top_i (
		.clk_i(clk_i), .reset_i(reset_i),
		.load_we_i(load_we_i), .load_adr_i(load_adr_i), .load_dat_i(load_dat_i),
		.wb_valid_o(wb_valid_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o),
		.dat_cyc_o(dat_cyc_o), .dat_we_o(dat_we_o), .dat_adr_o(dat_adr_o),
		.dat_dat_o(dat_dat_o), .halt_o(halt_o)
	);

	initial clk_i = 1'b0;
	always #20 clk_i = ~clk_i;

	task automatic abort_run();
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0d ns %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0d ns %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input pc_t got, input pc_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0d ns %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] t=%0d ns %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Lines are P (program word), W (writeback), S (store) and E (end).
	task automatic read_stimulus();
		int          fd;
		int          n;
		string       line;
		byte         kind;
		logic [31:0] a;
		logic [31:0] b;
		logic        seen_end;
		seen_end = 1'b0;
		fd = $fopen("test/cpu_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open test/cpu_stimulus.txt");
			abort_run();
		end
		while (!seen_end && !$feof(fd))
		begin
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 0)
			begin
				kind = line.getc(0);
				if (kind == "E")
					seen_end = 1'b1;
				else if (kind == "P" || kind == "W" || kind == "S")
				begin
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
					if (n != 2)
					begin
						$display("malformed stimulus line: %s", line);
						abort_run();
					end
					if (kind == "P")
					begin
						prog_adr.push_back(a[RAM_AWIDTH-1:0]);
						prog_dat.push_back(b);
					end
					else if (kind == "W")
					begin
						wb_rd_exp.push_back(a[3:0]);
						wb_val_exp.push_back(b);
					end
					else
					begin
						st_adr_exp.push_back(a);
						st_val_exp.push_back(b);
					end
				end
			end
		end
		$fclose(fd);
		if (!seen_end)
		begin
			$display("stimulus file has no end marker");
			abort_run();
		end
		if (prog_dat.size() >= RESET_CYCLES)
		begin
			$display("program has %0d words and does not fit in reset", prog_dat.size());
			abort_run();
		end
	endtask

	task automatic wait_for_halt();
		int n;
		n = 0;
		while (halt_o !== 1'b1 && n < TIMEOUT)
		begin
			@(negedge clk_i);
			n++;
		end
		if (halt_o !== 1'b1)
		begin
			$display("halt_o did not rise within %0d cycles", TIMEOUT);
			abort_run();
		end
	endtask

	// Outputs must stay quiet through reset.
	always @(negedge clk_i)
	begin
		if (reset_i)
		begin
			check_flag("wb_valid_o", wb_valid_o, 1'b0);
			check_flag("dat_cyc_o", dat_cyc_o, 1'b0);
			check_flag("halt_o", halt_o, 1'b0);
		end
	end

	always @(negedge clk_i)
	begin
		if (!reset_i && wb_valid_o !== 1'b0)
		begin
			if (halt_o === 1'b1)
			begin
				$display("writeback to r%0d seen after halt_o", wb_addr_o);
				abort_run();
			end
			else if (wb_rd_exp.size() == 0)
			begin
				$display("extra writeback to r%0d with %h", wb_addr_o, wb_data_o);
				abort_run();
			end
			else
			begin
				check_reg("wb_addr_o", wb_addr_o, wb_rd_exp.pop_front());
				check_word("wb_data_o", wb_data_o, wb_val_exp.pop_front());
			end
		end
	end

	// A bus cycle is counted once, on its first cycle.
	always @(negedge clk_i)
	begin
		if (reset_i)
			cyc_q = 1'b0;
		else
		begin
			if (dat_cyc_o === 1'b1 && cyc_q !== 1'b1)
			begin
				if (halt_o === 1'b1)
				begin
					$display("data bus cycle at %h seen after halt_o", dat_adr_o);
					abort_run();
				end
				else if (dat_we_o === 1'b1)
				begin
					if (st_adr_exp.size() == 0)
					begin
						$display("extra store to %h with %h", dat_adr_o, dat_dat_o);
						abort_run();
					end
					else
					begin
						check_addr("dat_adr_o", dat_adr_o, st_adr_exp.pop_front());
						check_word("dat_dat_o", dat_dat_o, st_val_exp.pop_front());
					end
				end
			end
			cyc_q = dat_cyc_o;
		end
	end

	initial
	begin
		reset_i    = 1'b1;
		load_we_i  = 1'b0;
		load_adr_i = '0;
		load_dat_i = '0;
		read_stimulus();
		for (int i = 1; i <= RESET_CYCLES; i++)
		begin
			@(posedge clk_i);
			if (i <= prog_dat.size())
			begin
				load_we_i  <= 1'b1;
				load_adr_i <= prog_adr[i-1];
				load_dat_i <= prog_dat[i-1];
			end
			else
				load_we_i <= 1'b0;
		end
		reset_i <= 1'b0;
		wait_for_halt();
		for (int i = 0; i < QUIET_CYCLES; i++)
		begin
			@(negedge clk_i);
			check_flag("halt_o", halt_o, 1'b1);
		end
		if (wb_rd_exp.size() != 0 || st_adr_exp.size() != 0)
		begin
			$display("%0d writebacks and %0d stores never appeared",
				wb_rd_exp.size(), st_adr_exp.size());
			abort_run();
		end
		else
		begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

// File: test/cpu_stimulus.txt
# P word_address instruction | W rd value | S byte_address value | E marks the end
# All numbers are hex; W and S lines are the expected results in program order.
P 000 61000005
W 1 00000005
P 001 62000007
W 2 00000007
P 002 13120000
W 3 0000000c
P 003 24310000
W 4 00000007
P 004 6b40fff7
W b fffffffe
P 005 80030800
S 800 0000000c
P 006 75000800
W 5 0000000c
P 007 56520000
W 6 0000000b
# r6 is not zero, so this branch falls through.
P 008 90600005
# Taken branch to word 00c skips the next two words.
P 009 90000002
P 00a 67000001
P 00b 68000002
P 00c 39640000
W 9 00000003
P 00d 4a9b0000
W a ffffffff
P 00e f0000000
E

// File: cpu_top.f
design/cpu_pkg.sv
design/cyc_bus_if.sv
design/stage_if.sv
design/ifetch.sv
design/idecode.sv
design/hazard.sv
design/execute.sv
design/mem.sv
design/ram2.sv
design/cpu_top.sv
test/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
RTL_TOP   ?= cpu_top
TB_TOP    ?= cpu_tb
FLIST     ?= cpu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timescale 1ns/1ps --timing --assert
PASS_MSG  ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
